//--- common/cpu16_pkg.sv
// CPU16 shared definitions
package cpu16_pkg;

   // Data and address width
   localparam int xlen = 16;

   // Register index width, eight registers
   localparam int reg_addr_w = 3;

   // Instruction memory size in 16-bit words
   localparam int rom_depth = 256;

   // Word address width, taken from pc bits 8 down to 1
   localparam int rom_aw = $clog2(rom_depth);

   // Width of the short immediate in the I format
   localparam int imm_w = 6;

   // First fetch address after reset
   localparam logic [xlen-1:0] reset_pc = '0;

   // Opcodes, anything not listed here runs as a no-op
   localparam logic [3:0] op_alu  = 4'h1;
   localparam logic [3:0] op_addi = 4'h2;
   localparam logic [3:0] op_lui  = 4'h3;
   localparam logic [3:0] op_beqz = 4'h4;
   localparam logic [3:0] op_bnez = 4'h5;
   localparam logic [3:0] op_halt = 4'hf;

   // ALU function codes, carried in funct for op_alu
   localparam logic [2:0] fn_add = 3'd0;
   localparam logic [2:0] fn_sub = 3'd1;
   localparam logic [2:0] fn_and = 3'd2;
   localparam logic [2:0] fn_or  = 3'd3;
   localparam logic [2:0] fn_xor = 3'd4;
   localparam logic [2:0] fn_sll = 3'd5;
   localparam logic [2:0] fn_srl = 3'd6;
   // Signed compare, result is 0 or 1
   localparam logic [2:0] fn_slt = 3'd7;

   // One instruction word, seen in two formats
   // Opcode, rd and rs1 sit at the same bits in both views
   typedef union packed {
      // Register-register format
      struct packed {
         logic [3:0]            opcode;
         logic [reg_addr_w-1:0] rd;
         logic [reg_addr_w-1:0] rs1;
         logic [reg_addr_w-1:0] rs2;
         logic [2:0]            funct;
      } r;
      // Immediate format, also used by branches
      struct packed {
         logic [3:0]            opcode;
         logic [reg_addr_w-1:0] rd;
         logic [reg_addr_w-1:0] rs1;
         logic [imm_w-1:0]      imm6;
      } i;
   } instr_t;

endpackage

//--- fetch/instr_rom.sv
// Instruction memory
`timescale 1ns/100ps

module instr_rom import cpu16_pkg::*; (
   input  logic              clk,
   input  logic              rd_en,
   input  logic [rom_aw-1:0] addr,
   output instr_t            rdata,
   input  logic              prog_we,
   input  logic [rom_aw-1:0] prog_addr,
   input  instr_t            prog_data
);

   // Program storage, filled through the load port
   instr_t mem [rom_depth];

   // Load port, used only while the core is not running
   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end
   end

   // Registered read, output holds while rd_en is low
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rdata <= mem[addr];
      end
   end

   // Fetch is frozen during load, so the two ports never collide
   a_no_rw_collision: assert property (
      @(posedge clk) !(prog_we && rd_en && (prog_addr == addr))
   ) else $error("instr_rom: load and fetch hit word %0d together", addr);

endmodule

//--- fetch/fetch_unit.sv
// Instruction fetch unit
`timescale 1ns/100ps

module fetch_unit import cpu16_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              stall,
   input  logic              redirect,
   input  logic [xlen-1:0]   redirect_pc,
   input  logic              prog_we,
   input  logic [rom_aw-1:0] prog_addr,
   input  instr_t            prog_data,
   output instr_t            instr,
   output logic [xlen-1:0]   pc,
   output logic              f_valid
);

   // Address being issued to the memory this cycle
   logic [xlen-1:0] pc_q;
   // Address of the word now on instr
   logic [xlen-1:0] f_pc;
   // Set when the word on instr must not run
   logic            squash;
   logic            rd_en;

   // Memory holds its word while the pipeline is frozen
   assign rd_en = !stall;

   // Redirect wins over stall so a branch is never lost
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q <= reset_pc;
      end else if (redirect) begin
         pc_q <= redirect_pc;
      end else if (!stall) begin
         pc_q <= pc_q + 16'd2;
      end
   end

   // pc of the word read on this edge
   always_ff @(posedge clk) begin
      if (!stall) begin
         f_pc <= pc_q;
      end
   end

   // Squash covers the word read in the redirect cycle
   // Out of reset the memory output is stale, so start squashed
   always_ff @(posedge clk) begin
      if (rst) begin
         squash <= 1'b1;
      end else if (redirect) begin
         squash <= 1'b1;
      end else if (!stall) begin
         squash <= 1'b0;
      end
   end

   instr_rom u_rom (
      .clk       (clk),
      .rd_en     (rd_en),
      .addr      (pc_q[rom_aw:1]),
      .rdata     (instr),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data)
   );

   assign pc      = f_pc;
   assign f_valid = !squash;

   // Targets from control keep the halfword alignment
   a_pc_even: assert property (
      @(posedge clk) disable iff (rst) !pc_q[0]
   ) else $error("fetch_unit: odd pc %h", pc_q);

endmodule

//--- logic/alu.sv
// Execute stage ALU
`timescale 1ns/100ps

module alu import cpu16_pkg::*; (
   input  logic [xlen-1:0] a,
   input  logic [xlen-1:0] b,
   input  logic [2:0]      fn,
   output logic [xlen-1:0] result,
   output logic            a_zero
);

   // Shift distance from the low bits of b
   logic [3:0] shamt;

   assign shamt = b[3:0];

   always_comb begin
      case (fn)
         fn_add: begin
            result = a + b;
         end
         fn_sub: begin
            result = a - b;
         end
         fn_and: begin
            result = a & b;
         end
         fn_or: begin
            result = a | b;
         end
         fn_xor: begin
            result = a ^ b;
         end
         fn_sll: begin
            result = a << shamt;
         end
         fn_srl: begin
            // Logical, zeros shift in
            result = a >> shamt;
         end
         fn_slt: begin
            result = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
         end
         default: begin
            result = a + b;
         end
      endcase
   end

   // Branch condition, tested on the rs1 operand
   assign a_zero = (a == '0);

endmodule

//--- logic/reg_file.sv
// Register file
`timescale 1ns/100ps

module reg_file import cpu16_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [reg_addr_w-1:0] rs1_addr,
   input  logic [reg_addr_w-1:0] rs2_addr,
   output logic [xlen-1:0]       rs1_data,
   output logic [xlen-1:0]       rs2_data,
   input  logic                  we,
   input  logic [reg_addr_w-1:0] waddr,
   input  logic [xlen-1:0]       wdata
);

   logic [xlen-1:0] regs [2**reg_addr_w];

   // r0 is never written
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k < 2**reg_addr_w; k++) begin
            regs[k] <= '0;
         end
      end else if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // Write-first read, the execute result reaches decode in the same cycle
   always_comb begin
      if (rs1_addr == '0) begin
         rs1_data = '0;
      end else if (we && (waddr == rs1_addr)) begin
         rs1_data = wdata;
      end else begin
         rs1_data = regs[rs1_addr];
      end
      if (rs2_addr == '0) begin
         rs2_data = '0;
      end else if (we && (waddr == rs2_addr)) begin
         rs2_data = wdata;
      end else begin
         rs2_data = regs[rs2_addr];
      end
   end

endmodule

//--- logic/pipeline_control.sv
// Decode and pipeline control
`timescale 1ns/100ps

module pipeline_control import cpu16_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  instr_t                instr,
   input  logic                  f_valid,
   input  logic [xlen-1:0]       pc,
   input  logic                  cond_zero,
   output logic [reg_addr_w-1:0] rs1_addr,
   output logic [reg_addr_w-1:0] rs2_addr,
   output logic [2:0]            alu_fn,
   output logic                  use_imm,
   output logic [xlen-1:0]       imm,
   output logic                  ex_en,
   output logic                  rf_we,
   output logic [reg_addr_w-1:0] rf_waddr,
   output logic                  stall,
   output logic                  redirect,
   output logic [xlen-1:0]       redirect_pc,
   output logic                  halted
);

   logic [xlen-1:0]       imm_sext;
   logic [xlen-1:0]       d_target;
   logic                  d_valid;
   logic                  d_writes;
   logic                  ex_valid;
   logic [3:0]            ex_op;
   logic [reg_addr_w-1:0] ex_rd;
   logic [xlen-1:0]       ex_target;
   logic                  ex_writes;
   logic                  taken;
   logic                  halt_ex;

   // Decode through both views of the same word
   assign imm_sext = {{(xlen-imm_w){instr.i.imm6[imm_w-1]}}, instr.i.imm6};
   // LUI takes r0 so the ALU add passes the shifted immediate
   assign rs1_addr = (instr.i.opcode == op_lui) ? '0 : instr.i.rs1;
   assign rs2_addr = instr.r.rs2;
   assign alu_fn   = (instr.r.opcode == op_alu) ? instr.r.funct : fn_add;
   assign use_imm  = (instr.i.opcode == op_addi) || (instr.i.opcode == op_lui);
   assign imm      = (instr.i.opcode == op_lui) ?
                     {instr.i.imm6, {(xlen-imm_w){1'b0}}} : imm_sext;
   // Target is pc + 2 + imm * 2
   assign d_target = pc + 16'd2 + {imm_sext[xlen-2:0], 1'b0};

   // Writes to r0 are dropped in decode so no pulse leaves the core
   assign d_writes = ((instr.i.opcode == op_alu) || (instr.i.opcode == op_addi) ||
                      (instr.i.opcode == op_lui)) && (instr.i.rd != '0);

   // Execute stage status
   assign halt_ex   = ex_valid && (ex_op == op_halt);
   assign taken     = ex_valid && (((ex_op == op_beqz) && cond_zero) ||
                                   ((ex_op == op_bnez) && !cond_zero));

   // Fetch freezes on run low and from halt on
   assign stall       = !run || halted || halt_ex;
   assign redirect    = taken;
   assign redirect_pc = ex_target;

   // Decode word is dropped when the branch ahead of it is taken
   assign d_valid = f_valid && !taken;
   // A frozen decode word stays put and execute gets a bubble
   assign ex_en   = d_valid && !stall;

   assign rf_we    = ex_valid && ex_writes;
   assign rf_waddr = ex_rd;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_valid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         ex_valid <= ex_en;
         if (halt_ex) begin
            halted <= 1'b1;
         end
      end
   end

   // Execute payload follows the valid bit
   always_ff @(posedge clk) begin
      if (ex_en) begin
         ex_op     <= instr.i.opcode;
         ex_rd     <= instr.i.rd;
         ex_target <= d_target;
         ex_writes <= d_writes;
      end
   end

   // Once halted nothing is left in execute to branch
   a_no_redirect_halted: assert property (
      @(posedge clk) disable iff (rst) !(redirect && halted)
   ) else $error("pipeline_control: redirect after halt");

   a_no_r0_write: assert property (
      @(posedge clk) disable iff (rst) rf_we |-> (rf_waddr != '0)
   ) else $error("pipeline_control: write enable to r0");

endmodule

//--- logic/cpu16_core.sv
// CPU16 core top level
`timescale 1ns/100ps

module cpu16_core import cpu16_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic                  prog_we,
   input  logic [rom_aw-1:0]     prog_addr,
   input  instr_t                prog_data,
   output logic                  wb_valid,
   output logic [reg_addr_w-1:0] wb_reg,
   output logic [xlen-1:0]       wb_data,
   output logic                  halted
);

   // Fetch to decode
   instr_t                instr;
   logic [xlen-1:0]       f_pc;
   logic                  f_valid;
   // Control to fetch
   logic                  stall;
   logic                  redirect;
   logic [xlen-1:0]       redirect_pc;
   // Decode outputs
   logic [reg_addr_w-1:0] rs1_addr;
   logic [reg_addr_w-1:0] rs2_addr;
   logic [xlen-1:0]       rs1_data;
   logic [xlen-1:0]       rs2_data;
   logic [2:0]            alu_fn;
   logic                  use_imm;
   logic [xlen-1:0]       imm;
   logic                  ex_en;
   // Writeback
   logic                  rf_we;
   logic [reg_addr_w-1:0] rf_waddr;
   logic [xlen-1:0]       alu_result;
   logic                  cond_zero;
   // Execute stage operands
   logic [xlen-1:0]       ex_a;
   logic [xlen-1:0]       ex_b;
   logic [xlen-1:0]       ex_imm;
   logic                  ex_use_imm;
   logic [2:0]            ex_fn;
   logic [xlen-1:0]       ex_pc;
   logic [xlen-1:0]       alu_b;

   fetch_unit u_fetch (
      .clk         (clk),
      .rst         (rst),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .prog_we     (prog_we),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data),
      .instr       (instr),
      .pc          (f_pc),
      .f_valid     (f_valid)
   );

   pipeline_control u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .instr       (instr),
      .f_valid     (f_valid),
      .pc          (f_pc),
      .cond_zero   (cond_zero),
      .rs1_addr    (rs1_addr),
      .rs2_addr    (rs2_addr),
      .alu_fn      (alu_fn),
      .use_imm     (use_imm),
      .imm         (imm),
      .ex_en       (ex_en),
      .rf_we       (rf_we),
      .rf_waddr    (rf_waddr),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .halted      (halted)
   );

   reg_file u_rf (
      .clk      (clk),
      .rst      (rst),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .we       (rf_we),
      .waddr    (rf_waddr),
      .wdata    (alu_result)
   );

   // Operands move into execute with the instruction
   always_ff @(posedge clk) begin
      if (ex_en) begin
         ex_a       <= rs1_data;
         ex_b       <= rs2_data;
         ex_imm     <= imm;
         ex_use_imm <= use_imm;
         ex_fn      <= alu_fn;
         ex_pc      <= f_pc;
      end
   end

   assign alu_b = ex_use_imm ? ex_imm : ex_b;

   alu u_alu (
      .a      (ex_a),
      .b      (alu_b),
      .fn     (ex_fn),
      .result (alu_result),
      .a_zero (cond_zero)
   );

   // Writeback port mirrors the register file write
   assign wb_valid = rf_we;
   assign wb_reg   = rf_waddr;
   assign wb_data  = alu_result;

   // Branches only go forward, so every target lies past the branch
   a_forward_branch: assert property (
      @(posedge clk) disable iff (rst) redirect |-> (redirect_pc > ex_pc)
   ) else $error("cpu16_core: backward branch from %h to %h", ex_pc, redirect_pc);

endmodule

//--- verification/cpu16_ref_model.svh
// CPU16 instruction-level model
`ifndef CPU16_REF_MODEL_SVH
`define CPU16_REF_MODEL_SVH

// Expected register writes in program order
logic [reg_addr_w-1:0] exp_reg_q [$];
logic [xlen-1:0]       exp_data_q [$];
int                    exp_total;

// Result of one ALU function, as the instruction set defines it
function automatic logic [xlen-1:0] expected_alu(input logic [2:0] fn,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
   logic signed [xlen-1:0] sa;
   logic signed [xlen-1:0] sb;
   logic [xlen-1:0]        res;
   sa = a;
   sb = b;
   case (fn)
      fn_add: res = a + b;
      fn_sub: res = a - b;
      fn_and: res = a & b;
      fn_or:  res = a | b;
      fn_xor: res = a ^ b;
      // Shift distance is b modulo 16
      fn_sll: res = a << b[3:0];
      fn_srl: res = a >> b[3:0];
      default: res = (sa < sb) ? 16'd1 : 16'd0;
   endcase
   return res;
endfunction

// Runs prog[0..n-1] from word 0 until HALT
task automatic execute_program(input int n);
   logic [xlen-1:0] regs [2**reg_addr_w];
   instr_t          w;
   logic [xlen-1:0] res;
   bit              writes;
   bit              done;
   int              idx;
   int              offs;
   for (int k = 0; k < 2**reg_addr_w; k++) begin
      regs[k] = '0;
   end
   exp_reg_q.delete();
   exp_data_q.delete();
   idx = 0;
   done = 0;
   while (!done && (idx < n)) begin
      w = prog[idx];
      writes = 0;
      res = '0;
      offs = int'($signed(w.i.imm6));
      idx = idx + 1;
      case (w.i.opcode)
         op_alu: begin
            res = expected_alu(w.r.funct, regs[w.r.rs1], regs[w.r.rs2]);
            writes = 1;
         end
         op_addi: begin
            res = regs[w.i.rs1] + {{(xlen-imm_w){w.i.imm6[imm_w-1]}}, w.i.imm6};
            writes = 1;
         end
         op_lui: begin
            res = {w.i.imm6, {(xlen-imm_w){1'b0}}};
            writes = 1;
         end
         // Taken branch skips imm words past the next one
         op_beqz: if (regs[w.i.rs1] == '0) idx = idx + offs;
         op_bnez: if (regs[w.i.rs1] != '0) idx = idx + offs;
         op_halt: done = 1;
         default: writes = 0;
      endcase
      // r0 stays zero and gives no writeback
      if (writes && (w.i.rd != '0)) begin
         regs[w.i.rd] = res;
         exp_reg_q.push_back(w.i.rd);
         exp_data_q.push_back(res);
      end
   end
   exp_total = exp_reg_q.size();
endtask

`endif

//--- verification/cpu16_tb.sv
// CPU16 core testbench
`timescale 1ns/100ps

module cpu16_tb import cpu16_pkg::*; ();

   localparam int num_tests       = 200;
   localparam int cycles_per_test = 500;
   localparam int clk_period      = 10;
   localparam int max_words       = 60;

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  prog_we;
   logic [rom_aw-1:0]     prog_addr;
   instr_t                prog_data;
   logic                  wb_valid;
   logic [reg_addr_w-1:0] wb_reg;
   logic [xlen-1:0]       wb_data;
   logic                  halted;

   // Current program, HALT is the last counted word
   instr_t prog [rom_depth];
   int     prog_len;
   int     wb_count;

   `include "cpu16_ref_model.svh"

   cpu16_core cpu16_core_inst (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .halted    (halted)
   );

   initial clk = 1'b0;
   always #(clk_period / 2) clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("ERR %0t: %s", $time, msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   // Random mix of ALU, ADDI, LUI, no-ops and forward branches
   task automatic generate_program();
      logic [15:0]           raw;
      instr_t                w;
      logic [reg_addr_w-1:0] last_rd;
      int                    n;
      int                    kind;
      int                    max_off;
      n = $urandom_range(max_words, 20);
      last_rd = '0;
      for (int k = 0; k < n - 1; k++) begin
         raw = 16'($urandom());
         w = raw;
         kind = $urandom_range(9);
         if (kind <= 2) begin
            w.r.opcode = op_alu;
         end else if (kind <= 4) begin
            w.i.opcode = op_addi;
         end else if (kind == 5) begin
            w.i.opcode = op_lui;
         end else if (kind == 6) begin
            // Undefined opcodes run as no-ops
            w.i.opcode = ($urandom_range(3) == 0) ? 4'h0 : 4'($urandom_range(14, 6));
         end else begin
            w.i.opcode = ($urandom_range(1) == 0) ? op_beqz : op_bnez;
            // Target stays inside the program
            max_off = (n - 2 - k > 31) ? 31 : n - 2 - k;
            w.i.imm6 = 6'($urandom_range(max_off, 0));
         end
         // Edge immediates, 0x8000 from LUI and -1 from ADDI
         if (((kind == 3) || (kind == 5)) && ($urandom_range(2) == 0)) begin
            case ($urandom_range(4))
               0: w.i.imm6 = 6'h00;
               1: w.i.imm6 = 6'h01;
               2: w.i.imm6 = 6'h1f;
               3: w.i.imm6 = 6'h20;
               default: w.i.imm6 = 6'h3f;
            endcase
         end
         // Often consume the previous result right away
         if ($urandom_range(1) == 1) begin
            w.i.rs1 = last_rd;
         end
         if (kind <= 5) begin
            last_rd = w.i.rd;
         end
         prog[k] = w;
      end
      raw = 16'($urandom());
      w = raw;
      w.i.opcode = op_halt;
      prog[n - 1] = w;
      // Words fetched past HALT are defined no-ops
      prog[n] = '0;
      prog[n + 1] = '0;
      prog_len = n;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst <= 1'b1;
      run <= 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic load_program(input int count);
      for (int k = 0; k < count; k++) begin
         @(posedge clk);
         prog_we   <= 1'b1;
         prog_addr <= rom_aw'(k);
         prog_data <= prog[k];
      end
      @(posedge clk);
      prog_we <= 1'b0;
   endtask

   task automatic check_writeback(input logic [reg_addr_w-1:0] got_reg,
                                  input logic [xlen-1:0] got_data);
      logic [reg_addr_w-1:0] exp_r;
      logic [xlen-1:0]       exp_d;
      if (exp_reg_q.size() == 0) begin
         stop_on_error($sformatf("unexpected writeback r%0d = %h", got_reg, got_data));
      end else begin
         exp_r = exp_reg_q.pop_front();
         exp_d = exp_data_q.pop_front();
         if ((got_reg !== exp_r) || (got_data !== exp_d)) begin
            stop_on_error($sformatf("writeback r%0d = %h, expected r%0d = %h",
                                    got_reg, got_data, exp_r, exp_d));
         end
      end
   endtask

   task automatic check_halt(input logic got_halted, input int got_count);
      if (got_halted !== 1'b1) begin
         stop_on_error("halted is not set after HALT");
      end else if ((got_count != exp_total) || (exp_reg_q.size() != 0)) begin
         stop_on_error($sformatf("%0d writebacks, expected %0d", got_count, exp_total));
      end
   endtask

   // Runs to halt with run dropped at random cycles
   task automatic run_program();
      bit done;
      wb_count = 0;
      done = 0;
      @(posedge clk);
      run <= 1'b1;
      while (!done) begin
         @(negedge clk);
         if (wb_valid) begin
            check_writeback(wb_reg, wb_data);
            wb_count++;
         end
         if (halted) begin
            done = 1;
         end else begin
            @(posedge clk);
            run <= ($urandom_range(7) != 0);
         end
      end
      // Nothing younger than HALT may write back
      for (int k = 0; k < 4; k++) begin
         @(negedge clk);
         if (wb_valid) begin
            stop_on_error($sformatf("writeback r%0d after halt", wb_reg));
         end
      end
      check_halt(halted, wb_count);
   endtask

   // Hang guard sized from the test count
   initial begin
      #(num_tests * cycles_per_test * clk_period);
      $display("Timeout: the core did not reach HALT within the allowed time");
      $display("TB FAILED");
      $fatal(1);
   end

   initial begin
      rst       = 1'b1;
      run       = 1'b0;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      void'($urandom(85766));
      for (int t = 0; t < num_tests; t++) begin
         generate_program();
         execute_program(prog_len);
         apply_reset();
         load_program(prog_len + 2);
         run_program();
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

//--- cpu16_core.f
+incdir+verification
common/cpu16_pkg.sv
fetch/instr_rom.sv
fetch/fetch_unit.sv
logic/alu.sv
logic/reg_file.sv
logic/pipeline_control.sv
logic/cpu16_core.sv
verification/cpu16_tb.sv

//--- Bender.yml
package:
  name: cpu16_core

sources:
  - common/cpu16_pkg.sv
  - fetch/instr_rom.sv
  - fetch/fetch_unit.sv
  - logic/alu.sv
  - logic/reg_file.sv
  - logic/pipeline_control.sv
  - logic/cpu16_core.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/cpu16_tb.sv
